// File: src/branch_pkg.sv
// Branch resolution definitions
`default_nettype none

package branch_pkg;

	// ========================================================================
	// Branch classes
	// ========================================================================

	// The class is set at decode and tells the resolver how to form the target
	typedef enum logic [2:0]
	{
		BRC_NONE = 3'd0,
		BRC_BCCD = 3'd1,
		BRC_BCCR = 3'd2,
		BRC_JSR  = 3'd3,
		BRC_RTD  = 3'd4,
		BRC_ERET = 3'd5
	} brclass_t;

	// ========================================================================
	// Micro-op word and its fields
	// ========================================================================

	typedef logic [47:0] uop_t;

	// Conditional branch displacement in half-word units
	localparam int UOP_DISP_LO = 28;
	localparam int UOP_DISP_HI = 47;
	// Condition code of a conditional branch
	localparam int UOP_COND_LO = 9;
	localparam int UOP_COND_HI = 12;
	// Long displacement of JSR, also in half-word units
	localparam int UOP_JSR_LO = 7;
	localparam int UOP_JSR_HI = 47;
	// ERET level field and the number of instructions to skip on return
	localparam int UOP_LVL_LO = 17;
	localparam int UOP_LVL_HI = 28;
	localparam int UOP_SKIP_LO = 6;
	localparam int UOP_SKIP_HI = 10;

	// Branch on interrupt takes the vector as its target
	localparam logic [3:0] CND_BOI = 4'hF;

	// ========================================================================
	// Addresses
	// ========================================================================

	// Wide enough for any PC width; users keep the low ABITS bits
	localparam logic [63:0] RSTPC = 64'hFFFF_FFFF_FFFC_0000;

	// All instructions are the same size
	localparam int INSN_BYTES = 6;

endpackage

`default_nettype wire

// File: src/branch_target.sv
// Branch destination calculation
`timescale 1ns/100ps
`default_nettype none

module branch_target import branch_pkg::*;
#(
	parameter int ABITS = 32
)
(
	input  brclass_t         br_class,
	input  uop_t             uop,
	input  logic [ABITS-1:0] pc,
	input  logic [ABITS-1:0] arg_a,
	input  logic [ABITS-1:0] arg_c,
	input  logic [ABITS-1:0] vector,
	input  logic [ABITS-1:0] stack_top0,
	input  logic [ABITS-1:0] stack_top1,
	output logic [ABITS-1:0] dst_pc
);

	// Field widths follow from the positions in the package
	localparam int DISP_W = UOP_DISP_HI - UOP_DISP_LO + 1;
	localparam int JSR_W = UOP_JSR_HI - UOP_JSR_LO + 1;
	localparam int COND_W = UOP_COND_HI - UOP_COND_LO + 1;
	localparam int LVL_W = UOP_LVL_HI - UOP_LVL_LO + 1;

	// Displacements are scaled by two, so each carries one extra low bit
	logic signed [DISP_W:0] bcc_ofs;
	logic signed [JSR_W:0]  jsr_ofs;
	logic [COND_W-1:0]      cond;
	logic [ABITS-1:0]       eret_base;
	logic [ABITS-1:0]       skip_ofs;

	// ========================================================================
	// Field extraction
	// ========================================================================

	always_comb
	begin
		bcc_ofs = {uop[UOP_DISP_HI:UOP_DISP_LO], 1'b0};
		jsr_ofs = {uop[UOP_JSR_HI:UOP_JSR_LO], 1'b0};
		cond = uop[UOP_COND_HI:UOP_COND_LO];
		// Level 3 returns through the second entry of the stack
		if (uop[UOP_LVL_HI:UOP_LVL_LO] == LVL_W'(3))
			eret_base = stack_top1;
		else
			eret_base = stack_top0;
		// The return may skip over a number of whole instructions
		skip_ofs = ABITS'(uop[UOP_SKIP_HI:UOP_SKIP_LO]) * ABITS'(INSN_BYTES);
	end

	// ========================================================================
	// Target selection
	// ========================================================================

	// The signed casts sign-extend the offsets to the PC width
	always_comb
	begin
		case (br_class)
			BRC_BCCD:
			begin
				// Branch on interrupt ignores the displacement field
				if (cond == CND_BOI)
					dst_pc = vector;
				else
					dst_pc = pc + ABITS'(bcc_ofs);
			end
			BRC_BCCR:
				dst_pc = arg_c;
			BRC_JSR:
				dst_pc = pc + ABITS'(jsr_ofs);
			BRC_RTD:
				dst_pc = arg_a;
			BRC_ERET:
				dst_pc = eret_base + skip_ofs;
			// Not a branch, so point somewhere harmless
			default:
				dst_pc = ABITS'(RSTPC);
		endcase
	end

endmodule

`default_nettype wire

// File: src/branch_miss_pc.sv
// Misprediction check and restart address
`timescale 1ns/100ps
`default_nettype none

module branch_miss_pc import branch_pkg::*;
#(
	parameter int ABITS = 32
)
(
	input  brclass_t         br_class,
	input  logic [ABITS-1:0] pc,
	input  logic [ABITS-1:0] dst_pc,
	input  logic             bt,
	input  logic             takb,
	output logic             miss,
	output logic [ABITS-1:0] miss_pc
);

	// Address of the instruction after the branch
	logic [ABITS-1:0] next_pc;

	assign next_pc = pc + ABITS'(INSN_BYTES);

	// ========================================================================
	// Decision
	// ========================================================================

	// Fetch followed bt; the restart address is where execution really goes
	always_comb
	begin
		case (br_class)
			// Conditional branches miss when the guess and the outcome differ
			BRC_BCCD,
			BRC_BCCR:
			begin
				miss = bt ^ takb;
				if (takb)
					miss_pc = dst_pc;
				else
					miss_pc = next_pc;
			end
			// Unconditional flow changes always go to the target
			BRC_JSR,
			BRC_RTD,
			BRC_ERET:
			begin
				// Fetch missed unless it already predicted the branch taken
				miss = ~bt;
				miss_pc = dst_pc;
			end
			// Non-branches never redirect, and the unused codes act the same
			default:
			begin
				miss = 1'b0;
				miss_pc = next_pc;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: src/exc_pc_stack.sv
// Exception return address stack
`timescale 1ns/100ps
`default_nettype none

module exc_pc_stack import branch_pkg::*;
#(
	parameter int ABITS = 32,
	parameter int STACK_DEPTH = 9
)
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic             push,
	input  logic [ABITS-1:0] push_pc,
	input  logic             pop,
	output logic [ABITS-1:0] top0,
	output logic [ABITS-1:0] top1
);

	localparam int CNT_W = $clog2(STACK_DEPTH + 1);

	// Entry 0 is the top of the stack
	logic [ABITS-1:0] stk [STACK_DEPTH];
	logic [CNT_W-1:0] count;

	// ========================================================================
	// Occupancy
	// ========================================================================

	// A push and a pop together leave the depth unchanged
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			count <= '0;
		else if (push && !pop)
			count <= count + 1'b1;
		else if (pop && !push)
			count <= count - 1'b1;
	end

	// Entries shift as a whole; the count alone says which are live
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			stk[0] <= push_pc;
			// When popping too, only the top is replaced
			if (!pop)
				for (int i = 1; i < STACK_DEPTH; i++)
					stk[i] <= stk[i-1];
		end
		else if (pop)
		begin
			for (int i = 0; i < STACK_DEPTH - 1; i++)
				stk[i] <= stk[i+1];
		end
	end

	// Positions above the live depth read as the reset address
	assign top0 = (count > CNT_W'(0)) ? stk[0] : ABITS'(RSTPC);
	assign top1 = (count > CNT_W'(1)) ? stk[1] : ABITS'(RSTPC);

	// Exception nesting must stay within the stack depth
	assert property (@(posedge clk) disable iff (!arst_n)
		(push && !pop) |-> (count != CNT_W'(STACK_DEPTH)));
	// An ERET needs a matching exception entry before it
	assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> (count != '0));

endmodule

`default_nettype wire

// File: src/redirect_queue.sv
// Resolution record queue toward fetch
`timescale 1ns/100ps
`default_nettype none

module redirect_queue
#(
	parameter int ABITS = 32,
	parameter int QUEUE_DEPTH = 4,
	parameter int FETCH_CREDITS = 2
)
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic             wr_valid,
	input  logic             wr_miss,
	input  logic [ABITS-1:0] wr_pc,
	input  logic             fetch_credit,
	output logic             issue_credit,
	output logic             res_valid,
	output logic             res_miss,
	output logic [ABITS-1:0] res_pc
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
	// One spare state so an excess credit is visible to the check below
	localparam int FCR_W = $clog2(FETCH_CREDITS + 2);

	logic             mem_miss [QUEUE_DEPTH];
	logic [ABITS-1:0] mem_pc [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [FCR_W-1:0] fcred;
	logic             deq;

	// A record leaves when one is waiting and fetch has room for it
	assign deq = (count != '0) && (fcred != '0);

	// ========================================================================
	// Pointers and counters
	// ========================================================================

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			fcred <= FCR_W'(FETCH_CREDITS);
			issue_credit <= 1'b0;
		end
		else
		begin
			// Pointers wrap explicitly so any depth works
			if (wr_valid)
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (deq)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(wr_valid) - CNT_W'(deq);
			fcred <= fcred + FCR_W'(fetch_credit) - FCR_W'(deq);
			// The freed entry goes back to the issuer a cycle later
			issue_credit <= deq;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_valid)
		begin
			mem_miss[wr_ptr] <= wr_miss;
			mem_pc[wr_ptr] <= wr_pc;
		end
	end

	// Outputs come straight from flops, with no path from the inputs
	assign res_valid = deq;
	assign res_miss = mem_miss[rd_ptr];
	assign res_pc = mem_pc[rd_ptr];

	// The issuer's credits must keep it from overrunning the queue
	assert property (@(posedge clk) disable iff (!arst_n)
		wr_valid |-> (count != CNT_W'(QUEUE_DEPTH)));
	// Fetch may only return credits it was given
	assert property (@(posedge clk) disable iff (!arst_n)
		fcred <= FCR_W'(FETCH_CREDITS));

endmodule

`default_nettype wire

// File: src/branch_unit.sv
// Branch resolution unit
`timescale 1ns/100ps
`default_nettype none

module branch_unit import branch_pkg::*;
#(
	parameter int ABITS = 32,
	parameter int STACK_DEPTH = 9,
	parameter int QUEUE_DEPTH = 4,
	parameter int FETCH_CREDITS = 2
)
(
	input  logic             clk,
	input  logic             arst_n,
	input  logic             br_valid,
	input  brclass_t         br_class,
	input  uop_t             br_uop,
	input  logic [ABITS-1:0] br_pc,
	input  logic             br_bt,
	input  logic             br_takb,
	input  logic [ABITS-1:0] br_arg_a,
	input  logic [ABITS-1:0] br_arg_c,
	input  logic [ABITS-1:0] br_vector,
	input  logic             exc_push,
	input  logic [ABITS-1:0] exc_pc,
	input  logic             fetch_credit,
	output logic             br_credit,
	output logic             res_valid,
	output logic             res_miss,
	output logic [ABITS-1:0] res_pc
);

	// Stage one holds the accepted branch for one cycle
	logic             s1_valid;
	brclass_t         s1_class;
	uop_t             s1_uop;
	logic [ABITS-1:0] s1_pc;
	logic             s1_bt;
	logic             s1_takb;
	logic [ABITS-1:0] s1_arg_a;
	logic [ABITS-1:0] s1_arg_c;
	logic [ABITS-1:0] s1_vector;
	logic [ABITS-1:0] stack_top0;
	logic [ABITS-1:0] stack_top1;
	logic [ABITS-1:0] dst_pc;
	logic             miss;
	logic [ABITS-1:0] miss_pc;
	logic             eret_pop;

	// ========================================================================
	// Input stage
	// ========================================================================

	// Credits guarantee room downstream, so every branch is accepted
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= br_valid;
	end

	always_ff @(posedge clk)
	begin
		if (br_valid)
		begin
			s1_class <= br_class;
			s1_uop <= br_uop;
			s1_pc <= br_pc;
			s1_bt <= br_bt;
			s1_takb <= br_takb;
			s1_arg_a <= br_arg_a;
			s1_arg_c <= br_arg_c;
			s1_vector <= br_vector;
		end
	end

	// An ERET consumes its return address as it resolves
	assign eret_pop = s1_valid && (s1_class == BRC_ERET);

	// ========================================================================
	// Resolution
	// ========================================================================

	exc_pc_stack #(.ABITS(ABITS), .STACK_DEPTH(STACK_DEPTH)) u_stack (
		.clk(clk), .arst_n(arst_n), .push(exc_push), .push_pc(exc_pc),
		.pop(eret_pop), .top0(stack_top0), .top1(stack_top1)
	);

	branch_target #(.ABITS(ABITS)) u_target (
		.br_class(s1_class), .uop(s1_uop), .pc(s1_pc), .arg_a(s1_arg_a),
		.arg_c(s1_arg_c), .vector(s1_vector), .stack_top0(stack_top0),
		.stack_top1(stack_top1), .dst_pc(dst_pc)
	);

	branch_miss_pc #(.ABITS(ABITS)) u_miss (
		.br_class(s1_class), .pc(s1_pc), .dst_pc(dst_pc), .bt(s1_bt),
		.takb(s1_takb), .miss(miss), .miss_pc(miss_pc)
	);

	// Every resolved branch leaves a record, missed or not
	redirect_queue #(
		.ABITS(ABITS), .QUEUE_DEPTH(QUEUE_DEPTH), .FETCH_CREDITS(FETCH_CREDITS)
	) u_queue (
		.clk(clk), .arst_n(arst_n), .wr_valid(s1_valid), .wr_miss(miss),
		.wr_pc(miss_pc), .fetch_credit(fetch_credit), .issue_credit(br_credit),
		.res_valid(res_valid), .res_miss(res_miss), .res_pc(res_pc)
	);

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock
#(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 16
)
(
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Reset lets go on a falling edge, well away from the rising edge
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/branch_unit_tb.sv
// Branch unit testbench
`timescale 1ns/100ps
`default_nettype none

module branch_unit_tb import branch_pkg::*;
();

	localparam int ABITS = 32;
	localparam int STACK_DEPTH = 9;
	localparam int QUEUE_DEPTH = 4;
	localparam int FETCH_CREDITS = 2;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES = 8;
	localparam int DRAIN_CYCLES = 24;
	localparam int CYCLES_PER_REC = 40;
	localparam int MAX_REC = 64;
	localparam int REC_W = 260;
	localparam int SEED = 37;

	logic             clk;
	logic             arst_n;
	logic             br_valid;
	brclass_t         br_class;
	uop_t             br_uop;
	logic [ABITS-1:0] br_pc;
	logic             br_bt;
	logic             br_takb;
	logic [ABITS-1:0] br_arg_a;
	logic [ABITS-1:0] br_arg_c;
	logic [ABITS-1:0] br_vector;
	logic             exc_push;
	logic [ABITS-1:0] exc_pc;
	logic             fetch_credit;
	logic             br_credit;
	logic             res_valid;
	logic             res_miss;
	logic [ABITS-1:0] res_pc;

	// One golden line per branch, fields laid out as in the file's header
	logic [REC_W-1:0] golden [MAX_REC];
	int               n_rec;
	int               next_idx;
	int               done_cnt;
	// Issuer credits, records fetch still owes a credit for, and its stall
	int               credits;
	int               pending;
	int               hold;
	int               errors;
	int               tests;
	bit               loaded;
	bit               idle_bad;
	// Golden indices of branches in flight, oldest first
	int               exp_q [$];

	tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk(clk), .arst_n(arst_n)
	);

	branch_unit #(
		.ABITS(ABITS), .STACK_DEPTH(STACK_DEPTH), .QUEUE_DEPTH(QUEUE_DEPTH),
		.FETCH_CREDITS(FETCH_CREDITS)
	) UUT (
		.clk(clk), .arst_n(arst_n), .br_valid(br_valid), .br_class(br_class),
		.br_uop(br_uop), .br_pc(br_pc), .br_bt(br_bt), .br_takb(br_takb),
		.br_arg_a(br_arg_a), .br_arg_c(br_arg_c), .br_vector(br_vector),
		.exc_push(exc_push), .exc_pc(exc_pc), .fetch_credit(fetch_credit),
		.br_credit(br_credit), .res_valid(res_valid), .res_miss(res_miss),
		.res_pc(res_pc)
	);

	// ========================================================================
	// Checks
	// ========================================================================

	task automatic compare_miss(input int idx, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: test %0d miss flag %b, expected %b", $time, idx, got, exp);
			errors++;
		end
	endtask

	task automatic compare_pc(input int idx, input logic [ABITS-1:0] got,
		input logic [ABITS-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t: test %0d restart pc %h, expected %h", $time, idx, got, exp);
			errors++;
		end
	endtask

	// Outputs come from flops, so they hold steady across the falling edge
	task automatic sample_results();
		int               idx;
		int               err0;
		logic [REC_W-1:0] rec;
		brclass_t         cls;
		if (!res_valid)
			return;
		// A record may only leave while fetch still has a credit with the queue
		if (pending >= FETCH_CREDITS)
		begin
			$display("Result record at %0t arrived while fetch held no credits", $time);
			errors++;
		end
		// Fetch owes a credit back for every record it takes
		pending++;
		if (exp_q.size() == 0)
		begin
			$display("Result record at %0t arrived with no branch outstanding", $time);
			errors++;
			return;
		end
		idx = exp_q.pop_front();
		rec = golden[idx];
		cls = brclass_t'(rec[258:256]);
		err0 = errors;
		compare_miss(idx + 1, res_miss, rec[32]);
		compare_pc(idx + 1, res_pc, rec[31:0]);
		tests++;
		done_cnt++;
		$display("test %0d %s pc %h: %s", idx + 1, cls.name(), rec[207:176],
			(errors == err0) ? "ok" : "error");
	endtask

	// ========================================================================
	// Stimulus
	// ========================================================================

	// Mostly quick, but now and then fetch sits on its credits for a while
	function automatic int fetch_hold();
		if ($urandom % 4 == 0)
			return 16 + int'($urandom % 24);
		else
			return int'($urandom % 3);
	endfunction

	task automatic return_fetch_credit();
		fetch_credit = 1'b0;
		if (hold > 0)
			hold--;
		else if (pending > 0)
		begin
			fetch_credit = 1'b1;
			pending--;
			hold = fetch_hold();
		end
	endtask

	task automatic issue_next();
		logic [REC_W-1:0] rec;
		if (br_credit)
			credits++;
		br_valid = 1'b0;
		exc_push = 1'b0;
		// An occasional bubble varies the spacing between branches
		if (next_idx >= n_rec || credits == 0 || $urandom % 5 == 0)
			return;
		rec = golden[next_idx];
		br_valid = 1'b1;
		br_class = brclass_t'(rec[258:256]);
		br_uop = rec[255:208];
		br_pc = rec[207:176];
		br_bt = rec[172];
		br_takb = rec[168];
		br_arg_a = rec[167:136];
		br_arg_c = rec[135:104];
		br_vector = rec[103:72];
		// The exception push rides along with the branch of the same line
		exc_push = rec[68];
		exc_pc = rec[67:36];
		exp_q.push_back(next_idx);
		next_idx++;
		credits--;
	endtask

	task automatic advance_cycle();
		@(negedge clk);
		sample_results();
		return_fetch_credit();
		issue_next();
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial
	begin
		void'($urandom(SEED));
		br_valid = 1'b0;
		br_class = BRC_NONE;
		br_uop = '0;
		br_pc = '0;
		br_bt = 1'b0;
		br_takb = 1'b0;
		br_arg_a = '0;
		br_arg_c = '0;
		br_vector = '0;
		exc_push = 1'b0;
		exc_pc = '0;
		fetch_credit = 1'b0;
		next_idx = 0;
		done_cnt = 0;
		credits = QUEUE_DEPTH;
		pending = 0;
		hold = 0;
		errors = 0;
		tests = 0;
		// Lines the file does not fill keep the all-ones class as an end mark
		for (int i = 0; i < MAX_REC; i++)
			golden[i] = '1;
		$readmemh("bench/branch_golden.hex", golden);
		n_rec = 0;
		while (n_rec < MAX_REC && golden[n_rec][259:256] != 4'hF)
			n_rec++;
		loaded = 1'b1;
		if (n_rec == 0)
		begin
			$display("The golden file holds no records");
			errors++;
		end
		wait (arst_n === 1'b1);
		// Nothing is sent yet, so the output must stay quiet
		idle_bad = 1'b0;
		repeat (IDLE_CYCLES)
		begin
			@(negedge clk);
			if (res_valid)
				idle_bad = 1'b1;
		end
		tests++;
		if (idle_bad)
		begin
			$display("res_valid rose after reset before any branch was sent");
			errors++;
		end
		$display("test 0 idle after reset: %s", idle_bad ? "error" : "ok");
		while (done_cnt < n_rec)
			advance_cycle();
		// Extra cycles catch duplicates and let the last credits come home
		repeat (DRAIN_CYCLES)
			advance_cycle();
		if (credits != QUEUE_DEPTH)
		begin
			$display("Issuer ends with %0d credits instead of %0d", credits, QUEUE_DEPTH);
			errors++;
		end
		$display("summary: %0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// Allow each record its share of cycles on top of the reset
	initial
	begin
		wait (loaded);
		repeat (n_rec * CYCLES_PER_REC + RESET_CYCLES) @(posedge clk);
		$display("Timeout with %0d of %0d results received", done_cnt, n_rec);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
src/branch_pkg.sv
src/branch_target.sv
src/branch_miss_pc.sv
src/exc_pc_stack.sv
src/redirect_queue.sv
src/branch_unit.sv
bench/tb_clock.sv
bench/branch_unit_tb.sv

// File: Makefile
# Verilator build and run for the branch resolution unit

VERILATOR  ?= verilator
TOP        ?= branch_unit_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run fails unless the pass message shows up on a line of its own
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/branch_golden.hex
// cls_uop_pc_bt_takb_arga_argc_vector_push_pushpc_miss_restartpc, all in hex
// Each line is one branch; push puts pushpc on the exception stack as it is sent
// Conditional displacement, four bt/takb cases, then negative offsets
1_000100000000_00001000_0_0_0000A000_0000C000_0000F000_0_00000000_0_00001006
1_000100000000_00001000_0_1_0000A000_0000C000_0000F000_0_00000000_1_00001020
1_000100000000_00001000_1_0_0000A000_0000C000_0000F000_0_00000000_1_00001006
1_000100000000_00001000_1_1_0000A000_0000C000_0000F000_0_00000000_0_00001020
1_FFFF80000000_00002000_0_1_0000A000_0000C000_0000F000_0_00000000_1_00001FF0
1_FFFF80000000_00002000_1_0_0000A000_0000C000_0000F000_0_00000000_1_00002006
1_FFFF80000000_00002000_1_1_0000A000_0000C000_0000F000_0_00000000_0_00001FF0
1_FFFF80000000_00002000_0_0_0000A000_0000C000_0000F000_0_00000000_0_00002006
1_800000000000_00200000_0_1_0000A000_0000C000_0000F000_0_00000000_1_00100000
// Branch on interrupt goes to the vector when taken
1_000100001E00_00003000_1_1_0000A000_0000C000_0000F000_0_00000000_0_0000F000
1_000100001E00_00003000_0_1_0000A000_0000C000_0040F000_0_00000000_1_0040F000
1_000100001E00_00003000_1_0_0000A000_0000C000_0040F000_0_00000000_1_00003006
// Register conditional, JSR and RTD
2_000000000000_00004000_0_1_0000A000_0000C000_0000F000_0_00000000_1_0000C000
2_000000000000_00004000_0_0_0000A000_0000C000_0000F000_0_00000000_0_00004006
3_000000002000_00005000_1_1_0000A000_0000C000_0000F000_0_00000000_0_00005080
3_FFFFFFFFFE00_00005000_0_0_0000A000_0000C000_0000F000_0_00000000_1_00004FF8
4_000000000000_00006000_1_1_0000A000_0000C000_0000F000_0_00000000_0_0000A000
4_000000000000_00006000_0_0_0000A000_0000C000_0000F000_0_00000000_1_0000A000
// Two pushes, ERET level 3 skip 2, then level 0 skip 5
0_000000000000_00007000_0_0_0000A000_0000C000_0000F000_1_00010000_0_00007006
0_000000000000_00007006_0_0_0000A000_0000C000_0000F000_1_00020000_0_0000700C
5_000000060080_00008000_1_1_0000A000_0000C000_0000F000_0_00000000_0_0001000C
5_000000000140_00008010_0_0_0000A000_0000C000_0000F000_0_00000000_1_0001001E
0_000000000000_00009000_0_0_0000A000_0000C000_0000F000_1_00030000_0_00009006
5_000000000000_00009006_1_1_0000A000_0000C000_0000F000_0_00000000_0_00030000
// Mixed tail for ordering under withheld fetch credits
1_000010000000_0000A000_1_1_0000A000_0000C000_0000F000_0_00000000_0_0000A002
2_000000000000_0000B000_1_0_0000A000_0000C000_0000F000_0_00000000_1_0000B006
3_000000000080_0000C000_0_0_0000A000_0000C000_0000F000_0_00000000_1_0000C002
0_000000000000_0000D000_1_1_0000A000_0000C000_0000F000_0_00000000_0_0000D006
4_000000000000_0000E000_1_1_12345678_0000C000_0000F000_0_00000000_0_12345678
1_000100000000_0000F000_0_1_0000A000_0000C000_0000F000_0_00000000_1_0000F020
2_000000000000_00010000_1_1_0000A000_00C0FFEE_0000F000_0_00000000_0_00C0FFEE
